// File: fifo_bram_async.f
hdl/fifo_pkg.sv
hdl/fifo_dpram.sv
hdl/fifo_ptr_sync.sv
hdl/fifo_wr_ctrl.sv
hdl/fifo_rd_ctrl.sv
hdl/fifo_bram_async.sv
verif/tb_fifo_bram_async.sv

// File: Makefile
TOOL       = verilator
TOP        = tb_fifo_bram_async
FILELIST   = fifo_bram_async.f
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = TESTBENCH FAILED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Fails on a nonzero exit or when the log holds the fail message
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/tb_fifo_bram_async.sv
`timescale 1ns/1ps

module tb_fifo_bram_async;
    import fifo_pkg::*;

    // DUT runs with its default parameters
    localparam int ALMOST_FULL_VAL  = 461;
    localparam int ALMOST_EMPTY_VAL = 52;
    localparam int SYNC_STAGES      = 2;

    localparam int RESET_CYCLES  = 10;
    localparam int EXTRA_CYCLES  = 32;                  // Strobes past full or empty
    localparam int SETTLE_CYCLES = SYNC_STAGES + 6;     // clk_rd cycles, the slower clock
    localparam int NUM_PHASES    = 40;
    localparam int PHASE_MIN     = 40;                  // clk_wr cycles per phase
    localparam int PHASE_MAX     = 160;
    localparam int TOTAL_CYCLES  = RESET_CYCLES
                                 + 3 * (FIFO_DEPTH + EXTRA_CYCLES + 2 * SETTLE_CYCLES)
                                 + NUM_PHASES * (PHASE_MAX + 2 * SETTLE_CYCLES);
    localparam real WATCHDOG_NS  = 1.5 * TOTAL_CYCLES * 14.0;  // Slowest period

    typedef enum logic [2:0] {PH_IDLE, PH_WR_HEAVY, PH_RD_HEAVY, PH_FILL, PH_DRAIN} phase_t;

    logic       clk_wr;
    logic       clk_rd;
    logic       rst;
    logic       wr_dv;
    fifo_data_t wr_data;
    logic       rd_en;
    fifo_data_t rd_data;
    wr_status_t wr_status;
    rd_status_t rd_status;

    integer     seed        = 28156;
    phase_t     phase       = PH_IDLE;
    fifo_data_t model_q[$];                             // Words in write order
    fifo_data_t exp_rd_data = '0;                       // What the output register must hold
    int         drained     = 0;                        // Pops since last clear
    logic       checks_on   = 1'b0;
    int         data_errors  = 0;
    int         wr_errors    = 0;
    int         rd_errors    = 0;
    int         other_errors = 0;

    fifo_bram_async UUT (
        .rst       (rst),
        .clk_wr    (clk_wr),
        .wr_dv     (wr_dv),
        .wr_data   (wr_data),
        .wr_status (wr_status),
        .clk_rd    (clk_rd),
        .rd_en     (rd_en),
        .rd_data   (rd_data),
        .rd_status (rd_status)
    );

    // Unrelated clocks, edges at 5+10j and 7+14k
    initial begin
        clk_wr = 1'b0;
        forever #5 clk_wr = ~clk_wr;
    end

    initial begin
        clk_rd = 1'b0;
        forever #7 clk_rd = ~clk_rd;
    end

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    // True with probability eighths/8
    function automatic logic roll(input int eighths);
        return rand_below(8) < eighths;
    endfunction

    // Flags that must be up for this count, others left as seen
    function automatic wr_status_t required_wr_flags(input wr_status_t act, input int count);
        wr_status_t exp;
        exp = act;
        if (count >= FIFO_DEPTH)      exp.full        = 1'b1;
        if (count >= ALMOST_FULL_VAL) exp.almost_full = 1'b1;
        return exp;
    endfunction

    function automatic rd_status_t required_rd_flags(input rd_status_t act, input int count);
        rd_status_t exp;
        exp = act;
        if (count == 0)                exp.empty        = 1'b1;
        if (count <= ALMOST_EMPTY_VAL) exp.almost_empty = 1'b1;
        return exp;
    endfunction

    // Settled flags, exact rule
    function automatic wr_status_t exact_wr_flags(input int count);
        return '{full: (count == FIFO_DEPTH), almost_full: (count >= ALMOST_FULL_VAL)};
    endfunction

    function automatic rd_status_t exact_rd_flags(input int count);
        return '{empty: (count == 0), almost_empty: (count <= ALMOST_EMPTY_VAL)};
    endfunction

    task automatic check_data(input string name, input fifo_data_t exp, input fifo_data_t act);
        if (act !== exp) begin
            data_errors++;
            $display("FAILED at %0t ns: %s expected 0x%02h, got 0x%02h", $time, name, exp, act);
        end
    endtask

    task automatic check_wr_status(input string name, input wr_status_t exp,
                                   input wr_status_t act);
        if (act !== exp) begin
            wr_errors++;
            $display("FAILED at %0t ns: %s {full,almost_full} expected %b, got %b",
                     $time, name, exp, act);
        end
    endtask

    task automatic check_rd_status(input string name, input rd_status_t exp,
                                   input rd_status_t act);
        if (act !== exp) begin
            rd_errors++;
            $display("FAILED at %0t ns: %s {empty,almost_empty} expected %b, got %b",
                     $time, name, exp, act);
        end
    endtask

    // Write side model and driver
    always @(posedge clk_wr) begin
        if (rst && wr_dv && !wr_status.full) begin
            model_q.push_back(wr_data);                 // Accepted on this edge
        end
        #1;
        case (phase)
            PH_FILL:     wr_dv = 1'b1;
            PH_WR_HEAVY: wr_dv = roll(7);
            PH_RD_HEAVY: wr_dv = roll(3);
            default:     wr_dv = 1'b0;
        endcase
        wr_data = fifo_data_t'($random(seed));
    end

    // Read side model and driver
    always @(posedge clk_rd) begin
        if (rst && rd_en && !rd_status.empty) begin
            if (model_q.size() == 0) begin
                other_errors++;
                $display("ERROR at %0t ns: DUT accepted a read with no word in the model",
                         $time);
            end else begin
                exp_rd_data = model_q.pop_front();      // Shows on rd_data after this edge
                drained++;
            end
        end
        #1;
        case (phase)
            PH_DRAIN:    rd_en = 1'b1;
            PH_RD_HEAVY: rd_en = roll(7);
            PH_WR_HEAVY: rd_en = roll(3);
            default:     rd_en = 1'b0;
        endcase
    end

    // Mid-cycle checks, flags may lag but never lie
    always @(negedge clk_wr) begin
        if (checks_on) begin
            check_wr_status("wr_status", required_wr_flags(wr_status, model_q.size()), wr_status);
        end
    end

    always @(negedge clk_rd) begin
        if (checks_on) begin
            check_rd_status("rd_status", required_rd_flags(rd_status, model_q.size()), rd_status);
            check_data("rd_data", exp_rd_data, rd_data);  // Also holds while no read
        end
    end

    // Idle gap, then every flag must match the count exactly
    task automatic settle_and_check();
        phase = PH_IDLE;
        repeat (SETTLE_CYCLES) @(posedge clk_rd);
        @(negedge clk_rd);
        check_wr_status("wr_status", exact_wr_flags(model_q.size()), wr_status);
        check_rd_status("rd_status", exact_rd_flags(model_q.size()), rd_status);
        @(posedge clk_wr);                              // Phase changes only on write edges
    endtask

    // Read until empty, then keep strobing into the empty FIFO
    task automatic drain_until_empty();
        phase = PH_DRAIN;
        while (!rd_status.empty) @(posedge clk_rd);
        repeat (EXTRA_CYCLES) @(posedge clk_rd);
        settle_and_check();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired at %0t ns before the stimulus finished", $time);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int kind;
        int len;
        rst     = 1'b0;
        wr_dv   = 1'b0;
        wr_data = '0;
        rd_en   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_wr);
        #1 rst = 1'b1;

        // Values straight out of reset
        @(negedge clk_rd);
        check_wr_status("wr_status", '{full: 1'b0, almost_full: 1'b0}, wr_status);
        check_rd_status("rd_status", '{empty: 1'b1, almost_empty: 1'b1}, rd_status);
        check_data("rd_data", '0, rd_data);
        checks_on = 1'b1;
        @(posedge clk_wr);

        // Fill to full, then push against it
        phase = PH_FILL;
        while (!wr_status.full) @(posedge clk_wr);
        repeat (EXTRA_CYCLES) @(posedge clk_wr);
        settle_and_check();
        if (model_q.size() != FIFO_DEPTH) begin
            other_errors++;
            $display("ERROR: %0d words accepted by the fill, expected %0d",
                     model_q.size(), FIFO_DEPTH);
        end

        drained = 0;
        drain_until_empty();
        if (drained != FIFO_DEPTH) begin
            other_errors++;
            $display("ERROR: drain returned %0d words, expected %0d", drained, FIFO_DEPTH);
        end

        // Random mix of bursts and gaps
        for (int p = 0; p < NUM_PHASES; p++) begin
            kind = rand_below(3);
            len  = PHASE_MIN + rand_below(PHASE_MAX - PHASE_MIN + 1);
            case (kind)
                0:       phase = PH_WR_HEAVY;
                1:       phase = PH_RD_HEAVY;
                default: phase = PH_IDLE;
            endcase
            repeat (len) @(posedge clk_wr);
            if (kind == 2) begin
                settle_and_check();
            end
        end

        settle_and_check();
        drain_until_empty();

        $display("Error counts: data %0d, wr_status %0d, rd_status %0d, other %0d",
                 data_errors, wr_errors, rd_errors, other_errors);
        if (data_errors + wr_errors + rd_errors + other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/fifo_bram_async.sv
`timescale 1ns/1ps

module fifo_bram_async #(
    parameter int ALMOST_FULL_VAL  = 461,               // 90% of 512, rounded up
    parameter int ALMOST_EMPTY_VAL = 52,                // 10% of 512, rounded up
    parameter int SYNC_STAGES      = 2                  // Crossing depth, both ways
) (
    input  logic                 rst,                   // Shared by both domains

    // Write domain
    input  logic                 clk_wr,
    input  logic                 wr_dv,
    input  fifo_pkg::fifo_data_t wr_data,
    output fifo_pkg::wr_status_t wr_status,

    // Read domain
    input  logic                 clk_rd,
    input  logic                 rd_en,
    output fifo_pkg::fifo_data_t rd_data,
    output fifo_pkg::rd_status_t rd_status
);
    import fifo_pkg::*;

    ram_wr_t                ram_wr;                     // clk_wr
    logic [FIFO_ADDR_W-1:0] rd_addr;                    // clk_rd
    logic                   rd_fire;
    fifo_ptr_t              wr_gray;                    // clk_wr, raw
    fifo_ptr_t              wr_gray_sync;               // clk_rd
    fifo_ptr_t              rd_gray;                    // clk_rd, raw
    fifo_ptr_t              rd_gray_sync;               // clk_wr

    fifo_dpram u_ram (
        .clk_wr  (clk_wr),
        .clk_rd  (clk_rd),
        .rst     (rst),
        .ram_wr  (ram_wr),
        .rd_addr (rd_addr),
        .rd_fire (rd_fire),
        .rd_data (rd_data)
    );

    fifo_wr_ctrl #(.ALMOST_FULL_VAL(ALMOST_FULL_VAL)) u_wr (
        .clk_wr       (clk_wr),
        .rst          (rst),
        .wr_dv        (wr_dv),
        .wr_data      (wr_data),
        .rd_gray_sync (rd_gray_sync),
        .ram_wr       (ram_wr),
        .wr_gray      (wr_gray),
        .wr_status    (wr_status)
    );

    fifo_rd_ctrl #(.ALMOST_EMPTY_VAL(ALMOST_EMPTY_VAL)) u_rd (
        .clk_rd       (clk_rd),
        .rst          (rst),
        .rd_en        (rd_en),
        .wr_gray_sync (wr_gray_sync),
        .rd_addr      (rd_addr),
        .rd_fire      (rd_fire),
        .rd_gray      (rd_gray),
        .rd_status    (rd_status)
    );

    // Write pointer into clk_rd
    fifo_ptr_sync #(.SYNC_STAGES(SYNC_STAGES)) u_sync_w2r (
        .clk     (clk_rd),
        .rst     (rst),
        .ptr_in  (wr_gray),
        .ptr_out (wr_gray_sync)
    );

    // Read pointer into clk_wr
    fifo_ptr_sync #(.SYNC_STAGES(SYNC_STAGES)) u_sync_r2w (
        .clk     (clk_wr),
        .rst     (rst),
        .ptr_in  (rd_gray),
        .ptr_out (rd_gray_sync)
    );

endmodule

// File: hdl/fifo_rd_ctrl.sv
`timescale 1ns/1ps

module fifo_rd_ctrl #(
    parameter int ALMOST_EMPTY_VAL = 52                 // ~10% of depth
) (
    input  logic                             clk_rd,
    input  logic                             rst,
    input  logic                             rd_en,        // Read strobe
    input  fifo_pkg::fifo_ptr_t              wr_gray_sync, // Write pointer in clk_rd
    output logic [fifo_pkg::FIFO_ADDR_W-1:0] rd_addr,
    output logic                             rd_fire,      // Load RAM output register
    output fifo_pkg::fifo_ptr_t              rd_gray,      // To write domain
    output fifo_pkg::rd_status_t             rd_status
);
    import fifo_pkg::*;

    fifo_ptr_t rd_bin;                                  // Binary read pointer
    fifo_ptr_t rd_bin_nxt;
    fifo_ptr_t rd_gray_nxt;
    fifo_ptr_t wr_bin_sync;                             // Decoded write pointer
    fifo_ptr_t occ;
    fifo_ptr_t occ_nxt;
    logic      empty_nxt;
    logic      almost_empty_nxt;

    // Reads while empty fall on the floor
    assign rd_fire = rd_en && !rd_status.empty;
    assign rd_addr = rd_bin[FIFO_ADDR_W-1:0];           // Slot read on this edge

    assign rd_bin_nxt  = rd_bin + fifo_ptr_t'(rd_fire);
    assign rd_gray_nxt = bin2gray(rd_bin_nxt);

    // Lagging write pointer understates occupancy
    assign wr_bin_sync = gray2bin(wr_gray_sync);
    assign occ         = wr_bin_sync - rd_bin;
    assign occ_nxt     = wr_bin_sync - rd_bin_nxt;

    // Empty on exact Gray match including the wrap bit
    assign empty_nxt        = (rd_gray_nxt == wr_gray_sync);
    assign almost_empty_nxt = (occ_nxt <= fifo_ptr_t'(ALMOST_EMPTY_VAL));

    always_ff @(posedge clk_rd or negedge rst) begin
        if (!rst) begin
            rd_bin    <= '0;
            rd_gray   <= '0;
            rd_status <= '{empty: 1'b1, almost_empty: 1'b1}; // Nothing stored yet
        end else begin
            rd_bin    <= rd_bin_nxt;
            rd_gray   <= rd_gray_nxt;
            rd_status <= '{empty: empty_nxt, almost_empty: almost_empty_nxt};
        end
    end

    // Last read takes empty high on its own edge
    // Empty only drops once a new write pointer has crossed over

    // Never fetch a slot when no word is visible
    a_no_rd_empty: assert property (@(posedge clk_rd) disable iff (!rst)
        occ == '0 |-> !rd_fire)
        else $error("fifo_rd_ctrl: read issued with no word visible");

    // Empty flag agrees with the crossed write pointer
    a_empty_occ: assert property (@(posedge clk_rd) disable iff (!rst)
        rd_status.empty |-> occ == '0 || $changed(wr_gray_sync))
        else $error("fifo_rd_ctrl: empty with %0d words visible", occ);

endmodule

// File: hdl/fifo_wr_ctrl.sv
`timescale 1ns/1ps

module fifo_wr_ctrl #(
    parameter int ALMOST_FULL_VAL = 461                 // ~90% of depth
) (
    input  logic                 clk_wr,
    input  logic                 rst,
    input  logic                 wr_dv,                 // Write strobe
    input  fifo_pkg::fifo_data_t wr_data,
    input  fifo_pkg::fifo_ptr_t  rd_gray_sync,          // Read pointer already in clk_wr
    output fifo_pkg::ram_wr_t    ram_wr,
    output fifo_pkg::fifo_ptr_t  wr_gray,               // To read domain
    output fifo_pkg::wr_status_t wr_status
);
    import fifo_pkg::*;

    fifo_ptr_t wr_bin;                                  // Binary write pointer
    fifo_ptr_t wr_bin_nxt;
    fifo_ptr_t wr_gray_nxt;
    fifo_ptr_t rd_bin_sync;                             // Decoded read pointer
    fifo_ptr_t occ;                                     // Occupancy as seen now
    fifo_ptr_t occ_nxt;                                 // Occupancy after this edge
    logic      wr_accept;
    logic      full_nxt;
    logic      almost_full_nxt;

    // Drop the strobe when full
    assign wr_accept = wr_dv && !wr_status.full;

    assign wr_bin_nxt  = wr_bin + fifo_ptr_t'(wr_accept);
    assign wr_gray_nxt = bin2gray(wr_bin_nxt);

    // Stale read pointer only overstates occupancy
    assign rd_bin_sync = gray2bin(rd_gray_sync);
    assign occ         = wr_bin - rd_bin_sync;          // Wraps cleanly on the extra bit
    assign occ_nxt     = wr_bin_nxt - rd_bin_sync;

    // Full when Gray pointers match apart from the top two bits
    assign full_nxt = (wr_gray_nxt == {~rd_gray_sync[FIFO_PTR_W-1 -: 2],
                                       rd_gray_sync[FIFO_PTR_W-3:0]});
    assign almost_full_nxt = (occ_nxt >= fifo_ptr_t'(ALMOST_FULL_VAL));

    // Memory write beat to the current slot
    assign ram_wr = '{en:   wr_accept,
                      addr: wr_bin[FIFO_ADDR_W-1:0],
                      data: wr_data};

    always_ff @(posedge clk_wr or negedge rst) begin
        if (!rst) begin
            wr_bin    <= '0;
            wr_gray   <= '0;
            wr_status <= '{full: 1'b0, almost_full: 1'b0};
        end else begin
            wr_bin    <= wr_bin_nxt;
            wr_gray   <= wr_gray_nxt;                   // Registered for a glitch free crossing
            wr_status <= '{full: full_nxt, almost_full: almost_full_nxt};
        end
    end

    // Flags come from the next-state pointer
    // so the edge that takes the last slot also raises full

    // No memory beat goes out once a full lap is stored
    a_no_wr_full: assert property (@(posedge clk_wr) disable iff (!rst)
        occ == fifo_ptr_t'(FIFO_DEPTH) |-> !ram_wr.en)
        else $error("fifo_wr_ctrl: write issued with %0d words stored", occ);

    // Read domain must never run ahead of the writer
    a_occ_range: assert property (@(posedge clk_wr) disable iff (!rst)
        occ <= fifo_ptr_t'(FIFO_DEPTH))
        else $error("fifo_wr_ctrl: occupancy %0d beyond depth", occ);

    // Full means a full lap unless a read just crossed over
    a_full_lap: assert property (@(posedge clk_wr) disable iff (!rst)
        wr_status.full |-> occ == fifo_ptr_t'(FIFO_DEPTH) || $changed(rd_gray_sync))
        else $error("fifo_wr_ctrl: full flag without a full lap");

endmodule

// File: hdl/fifo_ptr_sync.sv
`timescale 1ns/1ps

module fifo_ptr_sync #(
    parameter int SYNC_STAGES = 2                       // Flops in the chain
) (
    input  logic                clk,                    // Destination clock
    input  logic                rst,
    input  fifo_pkg::fifo_ptr_t ptr_in,                 // Gray, from other domain
    output fifo_pkg::fifo_ptr_t ptr_out
);
    import fifo_pkg::*;

    fifo_ptr_t sync_q [SYNC_STAGES];                    // Stage 0 takes the raw crossing

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= ptr_in;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];               // Shift toward output
            end
        end
    end

    assign ptr_out = sync_q[SYNC_STAGES-1];

    // Source moves one Gray bit per source edge
    // A faster source may land a few steps per destination cycle
    // but the decoded pointer must only ever walk forward, never past a full lap
    a_gray_fwd: assert property (@(posedge clk) disable iff (!rst)
        fifo_ptr_t'(gray2bin(ptr_in) - gray2bin($past(ptr_in))) <= FIFO_DEPTH)
        else $error("fifo_ptr_sync: pointer jumped backward or by more than a lap");

endmodule

// File: hdl/fifo_dpram.sv
`timescale 1ns/1ps

module fifo_dpram (
    input  logic                             clk_wr,    // Write port clock
    input  logic                             clk_rd,    // Read port clock
    input  logic                             rst,       // Clears output register only
    input  fifo_pkg::ram_wr_t                ram_wr,    // en, addr, data
    input  logic [fifo_pkg::FIFO_ADDR_W-1:0] rd_addr,
    input  logic                             rd_fire,   // Accepted read this edge
    output fifo_pkg::fifo_data_t             rd_data
);
    import fifo_pkg::*;

    // Storage array, maps onto one block RAM
    fifo_data_t mem [FIFO_DEPTH];

    // Write port
    always_ff @(posedge clk_wr) begin
        if (ram_wr.en) begin
            mem[ram_wr.addr] <= ram_wr.data;
        end
    end

    // Registered read port
    // Word shows up right after the accepting edge, holds otherwise
    always_ff @(posedge clk_rd or negedge rst) begin
        if (!rst) begin
            rd_data <= '0;
        end else if (rd_fire) begin
            rd_data <= mem[rd_addr];
        end
    end

    // Write side
    // - only stores while the write controller sees room
    // Read side
    // - only fetches slots already published through the Gray crossing
    // So both ports never touch the same slot in the same window

endmodule

// File: hdl/fifo_pkg.sv
package fifo_pkg;

    // Geometry, fixed to the 8-bit BRAM mode
    localparam int FIFO_DATA_W = 8;
    localparam int FIFO_ADDR_W = 9;
    localparam int FIFO_DEPTH  = 1 << FIFO_ADDR_W;      // 512 slots
    localparam int FIFO_PTR_W  = FIFO_ADDR_W + 1;       // Extra wrap bit

    typedef logic [FIFO_DATA_W-1:0] fifo_data_t;
    typedef logic [FIFO_PTR_W-1:0]  fifo_ptr_t;         // Binary or Gray

    // Memory write port, one beat per clk_wr edge
    typedef struct packed {
        logic                   en;
        logic [FIFO_ADDR_W-1:0] addr;
        fifo_data_t             data;
    } ram_wr_t;

    typedef struct packed {
        logic full;
        logic almost_full;
    } wr_status_t;

    typedef struct packed {
        logic empty;
        logic almost_empty;
    } rd_status_t;

    // Binary to reflected Gray
    function automatic fifo_ptr_t bin2gray(input fifo_ptr_t b);
        return b ^ (b >> 1);
    endfunction

    // Gray back to binary, MSB down
    function automatic fifo_ptr_t gray2bin(input fifo_ptr_t g);
        fifo_ptr_t b;
        b[FIFO_PTR_W-1] = g[FIFO_PTR_W-1];
        for (int i = FIFO_PTR_W-2; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];                       // Running XOR of upper bits
        end
        return b;
    endfunction

endpackage
